// ==== cpuPkg.sv ====
package cpuPkg;

    // Instruction opcodes, held in the top five bits of IR.
    typedef enum logic [4:0] {
        ld    = 5'd0,
        st    = 5'd1,
        add   = 5'd2,
        sub   = 5'd3,
        andOp = 5'd4,
        orOp  = 5'd5,
        mul   = 5'd6,
        mfhi  = 5'd7,
        mflo  = 5'd8,
        halt  = 5'd9
    } opcodeT;

    typedef enum logic [3:0] {
        Idle,
        T0,
        T1,
        T2,
        T3,
        T4,
        T5,
        T6,
        Halted
    } stepT;

    typedef enum logic [2:0] {
        aluAdd,
        aluSub,
        aluAnd,
        aluOr,
        aluMul,
        aluInc // pass the bus through plus one.
    } aluOpT;

    typedef enum logic [1:0] {
        selRa,
        selRb,
        selRc
    } regSelT;

    localparam int OpcodeMsb = 31;
    localparam int RaLsb = 23;
    localparam int RbLsb = 19;
    localparam int RcLsb = 15;
    localparam int ImmWidth = 15;

endpackage

// ==== regFile.sv ====
`timescale 1ns/100ps
module regFile #(
    parameter int DataWidth = 32,
    parameter int RegCount = 16
) (
    input  logic                        Clock,
    input  logic                        rst,
    input  logic [DataWidth-1:0]        bus,
    input  logic                        regIn,
    input  logic                        regOut,
    input  logic [$clog2(RegCount)-1:0] wrIndex,
    input  logic [$clog2(RegCount)-1:0] rdIndex,
    output logic [DataWidth-1:0]        rdData
);

    logic [DataWidth-1:0] regs [RegCount];

    always_ff @(posedge Clock) begin
        if (rst) begin
            for (int i = 0; i < RegCount; i++) begin
                regs[i] <= '0;
            end
        end else if (regIn) begin
            regs[wrIndex] <= bus;
        end
    end

    // the read port only reaches the bus while regOut is high.
    assign rdData = regOut ? regs[rdIndex] : '0;

endmodule

// ==== alu.sv ====
`timescale 1ns/100ps
module alu import cpuPkg::*; #(
    parameter int DataWidth = 32
) (
    input  aluOpT                  aluOp,
    input  logic [DataWidth-1:0]   yValue,
    input  logic [DataWidth-1:0]   busValue,
    output logic [2*DataWidth-1:0] result
);

    logic [DataWidth-1:0]   lowHalf;
    logic [2*DataWidth-1:0] product;

    // Full unsigned product, both operands widened first.
    assign product = {{DataWidth{1'b0}}, yValue} * {{DataWidth{1'b0}}, busValue};

    always_comb begin
        case (aluOp)
            aluAdd: begin
                lowHalf = yValue + busValue;
            end
            aluSub: begin
                lowHalf = yValue - busValue; // wraps modulo two to the word width.
            end
            aluAnd: begin
                lowHalf = yValue & busValue;
            end
            aluOr: begin
                lowHalf = yValue | busValue;
            end
            aluInc: begin
                lowHalf = busValue + 1'b1; // used for PC plus one during fetch.
            end
            default: begin
                lowHalf = '0;
            end
        endcase
    end

    assign result = (aluOp == aluMul) ? product : {{DataWidth{1'b0}}, lowHalf};

endmodule

// ==== mdrPort.sv ====
`timescale 1ns/100ps
module mdrPort #(
    parameter int DataWidth = 32
) (
    input  logic                 Clock,
    input  logic                 rst,
    input  logic [DataWidth-1:0] bus,
    input  logic                 mdrIn,
    input  logic                 memRead,
    input  logic                 memWrite,
    input  logic [DataWidth-1:0] marValue,
    input  logic                 memAck,
    input  logic [DataWidth-1:0] memDataIn,
    output logic [DataWidth-1:0] mdrValue,
    output logic                 memDone,
    output logic                 memReq,
    output logic                 memWriteOut,
    output logic [DataWidth-1:0] memAddr,
    output logic [DataWidth-1:0] memDataOut
);

    typedef enum logic [1:0] {
        portIdle,
        portReq,
        portRelease,
        portDone
    } portStateT;

    portStateT            state;
    logic [DataWidth-1:0] mdr;

    always_ff @(posedge Clock) begin
        if (rst) begin
            state <= portIdle;
            memWriteOut <= 1'b0;
        end else begin
            case (state)
                portIdle: begin
                    if ((memRead || memWrite) && !memAck) begin
                        state <= portReq;
                        memWriteOut <= memWrite;
                    end
                end
                portReq: begin
                    if (memAck) begin
                        state <= portRelease; // request drops once the ack is seen.
                    end
                end
                portRelease: begin
                    if (!memAck) begin
                        state <= portDone;
                    end
                end
                default: begin
                    state <= portIdle;
                    memWriteOut <= 1'b0;
                end
            endcase
        end
    end

    // Write data is taken from the bus as the request starts.
    always_ff @(posedge Clock) begin
        if (state == portIdle && mdrIn) begin
            mdr <= bus;
        end else if (state == portReq && memAck && !memWriteOut) begin
            mdr <= memDataIn;
        end
    end

    assign memReq = (state == portReq);
    assign memDone = (state == portDone);
    assign memAddr = marValue;
    assign memDataOut = mdr;
    assign mdrValue = mdr;

endmodule

// ==== datapath.sv ====
`timescale 1ns/100ps
module datapath import cpuPkg::*; #(
    parameter int DataWidth = 32,
    parameter int RegCount = 16
) (
    input  logic                 Clock,
    input  logic                 rst,
    input  logic                 pcOut,
    input  logic                 mdrOut,
    input  logic                 zLowOut,
    input  logic                 zHighOut,
    input  logic                 hiOut,
    input  logic                 loOut,
    input  logic                 regOut,
    input  logic                 immOut,
    input  logic                 marIn,
    input  logic                 pcIn,
    input  logic                 irIn,
    input  logic                 yIn,
    input  logic                 zIn,
    input  logic                 hiIn,
    input  logic                 loIn,
    input  logic                 regIn,
    input  logic                 incPc,
    input  aluOpT                aluOp,
    input  regSelT               regSel,
    input  logic                 memRead,
    input  logic                 memWrite,
    input  logic                 memAck,
    input  logic [DataWidth-1:0] memDataIn,
    output opcodeT               opcode,
    output logic                 memDone,
    output logic                 memReq,
    output logic                 memWriteOut,
    output logic [DataWidth-1:0] memAddr,
    output logic [DataWidth-1:0] memDataOut
);

    localparam int IndexWidth = $clog2(RegCount);

    logic [DataWidth-1:0]   pc;
    logic [DataWidth-1:0]   ir;
    logic [DataWidth-1:0]   mar;
    logic [DataWidth-1:0]   y;
    logic [DataWidth-1:0]   hi;
    logic [DataWidth-1:0]   lo;
    logic [2*DataWidth-1:0] z;
    logic [DataWidth-1:0]   bus;
    logic [DataWidth-1:0]   immValue;
    logic [DataWidth-1:0]   regData;
    logic [DataWidth-1:0]   mdrValue;
    logic [2*DataWidth-1:0] aluResult;
    logic [IndexWidth-1:0]  regIndex;
    aluOpT                  aluFunc;

    assign opcode = opcodeT'(ir[OpcodeMsb -: $bits(opcodeT)]);
    assign immValue = {{(DataWidth-ImmWidth){ir[ImmWidth-1]}}, ir[ImmWidth-1:0]};

    always_comb begin
        case (regSel)
            selRb: begin
                regIndex = ir[RbLsb +: IndexWidth];
            end
            selRc: begin
                regIndex = ir[RcLsb +: IndexWidth];
            end
            default: begin
                regIndex = ir[RaLsb +: IndexWidth];
            end
        endcase
    end

    // Out-strobes are one-hot, so the bus is an and-or of the sources.
    assign bus = ({DataWidth{pcOut}} & pc)
               | ({DataWidth{mdrOut}} & mdrValue)
               | ({DataWidth{zLowOut}} & z[DataWidth-1:0])
               | ({DataWidth{zHighOut}} & z[2*DataWidth-1:DataWidth])
               | ({DataWidth{hiOut}} & hi)
               | ({DataWidth{loOut}} & lo)
               | ({DataWidth{immOut}} & immValue)
               | regData;

    assign aluFunc = incPc ? aluInc : aluOp;

    always_ff @(posedge Clock) begin
        if (rst) begin
            pc <= '0;
        end else if (pcIn) begin
            pc <= bus;
        end
    end

    always_ff @(posedge Clock) begin
        if (irIn) ir <= bus;
        if (marIn) mar <= bus;
        if (yIn) y <= bus;
        if (zIn) z <= aluResult;
        if (hiIn) hi <= bus;
        if (loIn) lo <= bus;
    end

    regFile #(.DataWidth(DataWidth), .RegCount(RegCount)) regs (
        .Clock   (Clock),
        .rst     (rst),
        .bus     (bus),
        .regIn   (regIn),
        .regOut  (regOut),
        .wrIndex (regIndex),
        .rdIndex (regIndex),
        .rdData  (regData)
    );

    alu #(.DataWidth(DataWidth)) aluUnit (
        .aluOp    (aluFunc),
        .yValue   (y),
        .busValue (bus),
        .result   (aluResult)
    );

    mdrPort #(.DataWidth(DataWidth)) memPort (
        .Clock       (Clock),
        .rst         (rst),
        .bus         (bus),
        .mdrIn       (memWrite),
        .memRead     (memRead),
        .memWrite    (memWrite),
        .marValue    (mar),
        .memAck      (memAck),
        .memDataIn   (memDataIn),
        .mdrValue    (mdrValue),
        .memDone     (memDone),
        .memReq      (memReq),
        .memWriteOut (memWriteOut),
        .memAddr     (memAddr),
        .memDataOut  (memDataOut)
    );

endmodule

// ==== controlUnit.sv ====
`timescale 1ns/100ps
module controlUnit import cpuPkg::*; (
    input  logic   Clock,
    input  logic   rst,
    input  opcodeT opcode,
    input  logic   memDone,
    output logic   pcOut,
    output logic   mdrOut,
    output logic   zLowOut,
    output logic   zHighOut,
    output logic   hiOut,
    output logic   loOut,
    output logic   regOut,
    output logic   immOut,
    output logic   marIn,
    output logic   pcIn,
    output logic   irIn,
    output logic   yIn,
    output logic   zIn,
    output logic   hiIn,
    output logic   loIn,
    output logic   regIn,
    output logic   incPc,
    output aluOpT  aluOp,
    output regSelT regSel,
    output logic   memRead,
    output logic   memWrite,
    output logic   halted
);

    stepT step;
    stepT stepNext;

    function automatic aluOpT aluFor(input opcodeT op);
        case (op)
            sub: return aluSub;
            andOp: return aluAnd;
            orOp: return aluOr;
            mul: return aluMul;
            default: return aluAdd;
        endcase
    endfunction

    always_ff @(posedge Clock) begin
        if (rst) begin
            step <= Idle;
        end else begin
            step <= stepNext;
        end
    end

    always_comb begin
        stepNext = step;
        pcOut = 1'b0;
        mdrOut = 1'b0;
        zLowOut = 1'b0;
        zHighOut = 1'b0;
        hiOut = 1'b0;
        loOut = 1'b0;
        regOut = 1'b0;
        immOut = 1'b0;
        marIn = 1'b0;
        pcIn = 1'b0;
        irIn = 1'b0;
        yIn = 1'b0;
        zIn = 1'b0;
        hiIn = 1'b0;
        loIn = 1'b0;
        regIn = 1'b0;
        incPc = 1'b0;
        aluOp = aluAdd;
        regSel = selRa;
        memRead = 1'b0;
        memWrite = 1'b0;
        case (step)
            Idle: begin
                stepNext = T0;
            end
            T0: begin
                pcOut = 1'b1;
                marIn = 1'b1;
                incPc = 1'b1;
                zIn = 1'b1;
                stepNext = T1;
            end
            T1: begin
                zLowOut = 1'b1;
                pcIn = 1'b1; // PC reloads the same value while the fetch waits.
                memRead = 1'b1;
                if (memDone) stepNext = T2;
            end
            T2: begin
                mdrOut = 1'b1;
                irIn = 1'b1;
                stepNext = T3;
            end
            T3: begin
                case (opcode)
                    ld, st: begin
                        immOut = 1'b1;
                        marIn = 1'b1;
                        stepNext = T4;
                    end
                    add, sub, andOp, orOp, mul: begin
                        regOut = 1'b1;
                        regSel = selRb;
                        yIn = 1'b1;
                        stepNext = T4;
                    end
                    mfhi, mflo: begin
                        hiOut = (opcode == mfhi);
                        loOut = (opcode == mflo);
                        regIn = 1'b1;
                        stepNext = T0;
                    end
                    halt: begin
                        stepNext = Halted;
                    end
                    default: begin
                        stepNext = T0; // unknown opcodes are skipped.
                    end
                endcase
            end
            T4: begin
                if (opcode == ld) begin
                    memRead = 1'b1;
                    if (memDone) stepNext = T5;
                end else if (opcode == st) begin
                    regOut = 1'b1;
                    memWrite = 1'b1; // MDR takes ra as the write starts.
                    if (memDone) stepNext = T0;
                end else begin
                    regOut = 1'b1;
                    regSel = selRc;
                    zIn = 1'b1;
                    aluOp = aluFor(opcode);
                    stepNext = T5;
                end
            end
            T5: begin
                mdrOut = (opcode == ld);
                zLowOut = (opcode != ld);
                loIn = (opcode == mul);
                regIn = (opcode != mul);
                stepNext = (opcode == mul) ? T6 : T0;
            end
            T6: begin
                zHighOut = 1'b1;
                hiIn = 1'b1;
                stepNext = T0;
            end
            Halted: begin
                stepNext = Halted;
            end
            default: begin
                stepNext = Idle;
            end
        endcase
    end

    assign halted = (step == Halted);

endmodule

// ==== cpuCore.sv ====
`timescale 1ns/100ps
module cpuCore import cpuPkg::*; #(
    parameter int DataWidth = 32,
    parameter int RegCount = 16
) (
    input  logic                 Clock,
    input  logic                 rst,
    input  logic                 memAck,
    input  logic [DataWidth-1:0] memDataIn,
    output logic                 memReq,
    output logic                 memWrite,
    output logic [DataWidth-1:0] memAddr,
    output logic [DataWidth-1:0] memDataOut,
    output logic                 halted
);

    logic   pcOut;
    logic   mdrOut;
    logic   zLowOut;
    logic   zHighOut;
    logic   hiOut;
    logic   loOut;
    logic   regOut;
    logic   immOut;
    logic   marIn;
    logic   pcIn;
    logic   irIn;
    logic   yIn;
    logic   zIn;
    logic   hiIn;
    logic   loIn;
    logic   regIn;
    logic   incPc;
    logic   memRead;
    logic   memWriteCtl; // write step request, not the memory pin.
    logic   memDone;
    aluOpT  aluOp;
    regSelT regSel;
    opcodeT opcode;

    controlUnit ctrl (
        .Clock    (Clock),
        .rst      (rst),
        .opcode   (opcode),
        .memDone  (memDone),
        .pcOut    (pcOut),
        .mdrOut   (mdrOut),
        .zLowOut  (zLowOut),
        .zHighOut (zHighOut),
        .hiOut    (hiOut),
        .loOut    (loOut),
        .regOut   (regOut),
        .immOut   (immOut),
        .marIn    (marIn),
        .pcIn     (pcIn),
        .irIn     (irIn),
        .yIn      (yIn),
        .zIn      (zIn),
        .hiIn     (hiIn),
        .loIn     (loIn),
        .regIn    (regIn),
        .incPc    (incPc),
        .aluOp    (aluOp),
        .regSel   (regSel),
        .memRead  (memRead),
        .memWrite (memWriteCtl),
        .halted   (halted)
    );

    datapath #(.DataWidth(DataWidth), .RegCount(RegCount)) dp (
        .Clock       (Clock),
        .rst         (rst),
        .pcOut       (pcOut),
        .mdrOut      (mdrOut),
        .zLowOut     (zLowOut),
        .zHighOut    (zHighOut),
        .hiOut       (hiOut),
        .loOut       (loOut),
        .regOut      (regOut),
        .immOut      (immOut),
        .marIn       (marIn),
        .pcIn        (pcIn),
        .irIn        (irIn),
        .yIn         (yIn),
        .zIn         (zIn),
        .hiIn        (hiIn),
        .loIn        (loIn),
        .regIn       (regIn),
        .incPc       (incPc),
        .aluOp       (aluOp),
        .regSel      (regSel),
        .memRead     (memRead),
        .memWrite    (memWriteCtl),
        .memAck      (memAck),
        .memDataIn   (memDataIn),
        .opcode      (opcode),
        .memDone     (memDone),
        .memReq      (memReq),
        .memWriteOut (memWrite),
        .memAddr     (memAddr),
        .memDataOut  (memDataOut)
    );

endmodule

// ==== tbClock.sv ====
`timescale 1ns/100ps
module tbClock #(
    parameter int HalfPeriod = 5,
    parameter int ResetCycles = 5
) (
    output logic Clock,
    output logic rst
);

    initial begin
        Clock = 1'b0;
        forever #HalfPeriod Clock = ~Clock;
    end

    initial begin
        rst = 1'b1;
        repeat (ResetCycles) @(posedge Clock);
        @(negedge Clock);
        rst = 1'b0; // released on a falling edge like every other input.
    end

endmodule

// ==== cpuCore_assertions.sv ====
`timescale 1ns/100ps
module cpuCoreAssertions #(
    parameter int DataWidth = 32
) (
    input logic                 Clock,
    input logic                 rst,
    input logic                 memReq,
    input logic                 memWrite,
    input logic                 memAck,
    input logic                 halted,
    input logic [DataWidth-1:0] memAddr,
    input logic [DataWidth-1:0] memDataOut
);

    int failCount = 0;

    reqHeld: assert property (@(posedge Clock) disable iff (rst)
        memReq && !memAck |=> memReq)
        else begin
            failCount++;
            $error("memReq dropped before memAck was seen");
        end

    reqStable: assert property (@(posedge Clock) disable iff (rst)
        memReq && !memAck |=> $stable(memAddr) && $stable(memDataOut) && $stable(memWrite))
        else begin
            failCount++;
            $error("address, data or direction changed during a pending request");
        end

    ackNeedsReq: assert property (@(posedge Clock) disable iff (rst)
        $rose(memAck) |-> memReq)
        else begin
            failCount++;
            $error("memAck rose without a pending memReq");
        end

    // a new request may only follow a cycle in which the ack was low.
    noRestart: assert property (@(posedge Clock) disable iff (rst)
        $rose(memReq) |-> !$past(memAck))
        else begin
            failCount++;
            $error("memReq restarted while memAck was still high");
        end

    resetState: assert property (@(posedge Clock) rst |=> !memReq && !halted)
        else begin
            failCount++;
            $error("memReq or halted active straight after reset");
        end

endmodule

bind cpuCore cpuCoreAssertions #(.DataWidth(DataWidth)) checks (
    .Clock      (Clock),
    .rst        (rst),
    .memReq     (memReq),
    .memWrite   (memWrite),
    .memAck     (memAck),
    .halted     (halted),
    .memAddr    (memAddr),
    .memDataOut (memDataOut)
);

// ==== cpuCoreTb.sv ====
`timescale 1ns/100ps
module cpuCoreTb import cpuPkg::*; ();

    localparam int DataWidth = 32;
    localparam int ProgramLength = 20;
    localparam int CycleLimit = 100 * ProgramLength;
    localparam logic [31:0] LfsrTaps = 32'h80200003;

    logic                 Clock;
    logic                 rst;
    logic                 memAck = 1'b0;
    logic [DataWidth-1:0] memDataIn = '0;
    logic                 memReq;
    logic                 memWrite;
    logic [DataWidth-1:0] memAddr;
    logic [DataWidth-1:0] memDataOut;
    logic                 halted;

    logic [31:0] image [64];
    logic [31:0] lfsrState = 32'h77ff2815;
    logic [31:0] expAddr [$];
    logic [31:0] expData [$];
    logic [31:0] opA;
    logic [31:0] opB;
    logic [63:0] product;
    logic        waiting = 1'b0;
    logic        firstSeen = 1'b0;
    int          waitLeft = 0;
    int          errors = 0;
    int          checks = 0;
    int          cycles = 0;

    tbClock clockGen (.Clock(Clock), .rst(rst));

    cpuCore #(.DataWidth(DataWidth), .RegCount(16)) dut (
        .Clock      (Clock),
        .rst        (rst),
        .memAck     (memAck),
        .memDataIn  (memDataIn),
        .memReq     (memReq),
        .memWrite   (memWrite),
        .memAddr    (memAddr),
        .memDataOut (memDataOut),
        .halted     (halted)
    );

    // galois LFSR that steps once per bit handed out.
    function automatic logic [31:0] takeBits(input int count);
        logic [31:0] value;
        logic        bitOut;
        value = '0;
        for (int i = 0; i < count; i++) begin
            bitOut = lfsrState[0];
            lfsrState = lfsrState >> 1;
            if (bitOut) lfsrState = lfsrState ^ LfsrTaps;
            value = {value[30:0], bitOut};
        end
        return value;
    endfunction

    // shift-and-add model of the full unsigned product.
    function automatic logic [63:0] shiftAddProduct(input logic [31:0] a, input logic [31:0] b);
        logic [63:0] acc;
        acc = '0;
        for (int i = 0; i < 32; i++) begin
            if (b[i]) acc = acc + ({32'd0, a} << i);
        end
        return acc;
    endfunction

    function automatic logic [31:0] encode(input opcodeT op, input int ra, input int rb,
                                           input int rc, input int imm);
        logic [31:0] word;
        word = '0;
        word[OpcodeMsb -: 5] = op;
        word[RaLsb +: 4] = ra[3:0];
        word[RbLsb +: 4] = rb[3:0];
        word[RcLsb +: 4] = rc[3:0];
        word[ImmWidth-1:0] = imm[ImmWidth-1:0];
        return word;
    endfunction

    task automatic expectWrite(input logic [31:0] addr, input logic [31:0] data);
        expAddr.push_back(addr);
        expData.push_back(data);
    endtask

    task automatic reportMismatch(input string what, input logic [31:0] got,
                                  input logic [31:0] want);
        $display("FAILED at %0t: %s is %h, expected %h", $time, what, got, want);
        errors++;
    endtask

    task automatic serveRequest();
        logic [5:0] index;
        index = memAddr[5:0];
        checks++;
        assert (memAddr < 64) else begin
            $display("Memory request at %h falls outside the 64-word image", memAddr);
            errors++;
        end
        if (!firstSeen) begin
            firstSeen = 1'b1;
            checks += 2;
            assert (!memWrite) else begin
                $display("The first memory request was a write instead of a fetch");
                errors++;
            end
            assert (memAddr == 0) else reportMismatch("first fetch address", memAddr, '0);
        end
        if (memWrite) begin
            if (expAddr.size() == 0) begin
                $display("Unexpected store of %h to address %h", memDataOut, memAddr);
                errors++;
            end else begin
                checks += 2;
                assert (memAddr == expAddr[0]) else
                    reportMismatch("store address", memAddr, expAddr[0]);
                assert (memDataOut == expData[0]) else
                    reportMismatch("store data", memDataOut, expData[0]);
                void'(expAddr.pop_front());
                void'(expData.pop_front());
            end
            image[index] = memDataOut;
        end else begin
            memDataIn <= image[index];
        end
    endtask

    // ack and its release each come 0 to 3 cycles late.
    always @(negedge Clock) begin
        if (rst) begin
            memAck <= 1'b0;
            waiting = 1'b0;
        end else if (memReq && !memAck) begin
            if (!waiting) begin
                waitLeft = int'(takeBits(2));
                waiting = 1'b1;
            end
            if (waitLeft == 0) begin
                serveRequest();
                memAck <= 1'b1;
                waiting = 1'b0;
            end else begin
                waitLeft--;
            end
        end else if (!memReq && memAck) begin
            if (!waiting) begin
                waitLeft = int'(takeBits(2));
                waiting = 1'b1;
            end
            if (waitLeft == 0) begin
                memAck <= 1'b0;
                waiting = 1'b0;
            end else begin
                waitLeft--;
            end
        end
    end

    always @(posedge Clock) begin
        cycles++;
        if (cycles >= CycleLimit) begin
            $display("Timeout: the core did not finish within %0d cycles", CycleLimit);
            $display("Checks: %0d, data errors: %0d, assertion failures: %0d",
                     checks, errors, dut.checks.failCount);
            $display("Regression failed");
            $finish;
        end
    end

    initial begin
        for (int i = 0; i < 64; i++) begin
            image[i] = 32'hc0de0000 + 32'(i * 3); // filler words are derived from their address.
        end
        opA = takeBits(32);
        opB = takeBits(32);
        image[40] = opA;
        image[41] = opB;
        image[0] = encode(ld, 1, 0, 0, 40);
        image[1] = encode(ld, 2, 0, 0, 41);
        image[2] = encode(st, 1, 0, 0, 50);
        image[3] = encode(st, 2, 0, 0, 51);
        image[4] = encode(add, 3, 1, 2, 0);
        image[5] = encode(st, 3, 0, 0, 52);
        image[6] = encode(sub, 4, 1, 2, 0);
        image[7] = encode(st, 4, 0, 0, 53);
        image[8] = encode(sub, 9, 2, 1, 0); // one of the two subtractions wraps.
        image[9] = encode(st, 9, 0, 0, 58);
        image[10] = encode(andOp, 5, 1, 2, 0);
        image[11] = encode(st, 5, 0, 0, 54);
        image[12] = encode(orOp, 6, 1, 2, 0);
        image[13] = encode(st, 6, 0, 0, 55);
        image[14] = encode(mul, 0, 1, 2, 0);
        image[15] = encode(mflo, 7, 0, 0, 0);
        image[16] = encode(mfhi, 8, 0, 0, 0);
        image[17] = encode(st, 7, 0, 0, 56);
        image[18] = encode(st, 8, 0, 0, 57);
        image[19] = encode(halt, 0, 0, 0, 0);

        product = shiftAddProduct(opA, opB);
        expectWrite(50, opA);
        expectWrite(51, opB);
        expectWrite(52, opA + opB);
        expectWrite(53, opA - opB);
        expectWrite(58, opB - opA);
        expectWrite(54, opA & opB);
        expectWrite(55, opA | opB);
        expectWrite(56, product[31:0]);
        expectWrite(57, product[63:32]);

        @(negedge rst);
        checks++;
        assert (!memReq && !halted) else begin
            $display("memReq or halted was active when reset was released");
            errors++;
        end

        wait (halted);
        repeat (20) begin
            @(negedge Clock);
            checks++;
            assert (!memReq) else begin
                $display("A memory request appeared after the core halted");
                errors++;
            end
        end
        checks++;
        assert (expAddr.size() == 0) else begin
            $display("%0d expected stores never reached memory", expAddr.size());
            errors++;
        end

        $display("Checks: %0d, data errors: %0d, assertion failures: %0d",
                 checks, errors, dut.checks.failCount);
        if (errors == 0 && dut.checks.failCount == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

// ==== filelist.f ====
cpuPkg.sv
regFile.sv
alu.sv
mdrPort.sv
datapath.sv
controlUnit.sv
cpuCore.sv
tbClock.sv
cpuCore_assertions.sv
cpuCoreTb.sv

// ==== run.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module cpuCoreTb \
    -f filelist.f -o simCpuCore

./obj_dir/simCpuCore +verilator+error+limit+1000 > sim.log 2>&1 || true
cat sim.log

if grep -q "Regression failed" sim.log || ! grep -q "Regression passed" sim.log; then
    echo "Simulation reported a failure, see sim.log"
    exit 1
fi
echo "Simulation finished without failures"
